// File: rtl/bar_cfg_pkg.sv
// warp and barrier sizing for the barrier unit, imported by every rtl file
package bar_cfg_pkg;

    // warps in the core
    localparam int NUM_WARPS = 8;

    // barrier numbering
    localparam int BAR_ADDR_BITS = 2;
    localparam int BAR_COUNT = 1 << BAR_ADDR_BITS;

    localparam int WARP_ID_BITS = $clog2(NUM_WARPS);

    // warp index, also carries a barrier size minus one
    typedef logic [WARP_ID_BITS-1:0] warp_id_t;

    // one bit per warp
    typedef logic [NUM_WARPS-1:0] warp_mask_t;

    typedef logic [BAR_ADDR_BITS-1:0] bar_addr_t;

    // extra bit so a deferred full count never wraps
    typedef logic [WARP_ID_BITS:0] warp_count_t;

endpackage

// File: rtl/bar_msg_pkg.sv
// request, marker, table entry and unlock formats shared by the barrier unit blocks
package bar_msg_pkg;

    import bar_cfg_pkg::*;

    // barrier request from the warp scheduler
    typedef struct packed {
        warp_id_t  wid;
        bar_addr_t addr;
        logic      is_arrive;
        // async arrivals count but never stall
        logic      is_async;
        warp_id_t  size_m1;
        // phase the warp saw when it issued a wait
        logic      phase;
    } bar_req_t;

    // transaction marker, start or done
    typedef struct packed {
        bar_addr_t addr;
        logic      is_done;
    } bar_tx_t;

    // per-barrier state held in the table
    typedef struct packed {
        warp_mask_t mask;
        logic       phase;
        logic       tx_pending;
        // all arrivals seen, release held for the transaction
        logic       arrived_all;
    } bar_entry_t;

    typedef struct packed {
        logic       valid;
        warp_mask_t mask;
    } bar_unlock_t;

endpackage

// File: rtl/bar_arrival_counter.sv
// per-barrier arrival counters, bumped or cleared by the sequencer each cycle
`timescale 1ns/10ps

module bar_arrival_counter (
    input  logic                     clk,
    input  logic                     reset,
    input  bar_cfg_pkg::bar_addr_t   addr,
    input  logic                     incr,
    input  logic                     clear,
    output bar_cfg_pkg::warp_count_t count
);

    import bar_cfg_pkg::*;

    warp_count_t counts [BAR_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BAR_COUNT; i++) begin
                counts[i] <= '0;
            end
        end else begin
            if (clear) begin
                counts[addr] <= '0;
            end else if (incr) begin
                counts[addr] <= counts[addr] + warp_count_t'(1);
            end
        end
    end

    // addressed count, read in the same cycle
    assign count = counts[addr];

    // the sequencer either counts an arrival or completes the barrier
    a_incr_clear_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(incr && clear)
    ) else $error("arrival counter got incr and clear together");

endmodule

// File: rtl/bar_state_table.sv
// barrier state table with wait masks, phases and transaction flags, plus a phase read port
`timescale 1ns/10ps

module bar_state_table (
    input  logic                    clk,
    input  logic                    reset,
    input  bar_cfg_pkg::bar_addr_t  addr,
    input  logic                    wr,
    input  bar_msg_pkg::bar_entry_t wr_entry,
    output bar_msg_pkg::bar_entry_t entry,
    input  bar_cfg_pkg::bar_addr_t  read_addr,
    output logic                    read_phase
);

    import bar_cfg_pkg::*;
    import bar_msg_pkg::*;

    bar_entry_t entries [BAR_COUNT];

    // every barrier starts idle at phase 0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BAR_COUNT; i++) begin
                entries[i] <= '0;
            end
        end else if (wr) begin
            entries[addr] <= wr_entry;
        end
    end

    // sequencer port, follows the active address
    assign entry = entries[addr];

    // outside phase port
    assign read_phase = entries[read_addr].phase;

endmodule

// File: rtl/bar_sequencer.sv
// decides what each barrier request or transaction marker does and registers the unlock pulse
`timescale 1ns/10ps

module bar_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  bar_msg_pkg::bar_req_t    req,
    input  logic                     tx_valid,
    input  bar_msg_pkg::bar_tx_t     tx,
    input  bar_msg_pkg::bar_entry_t  entry,
    input  bar_cfg_pkg::warp_count_t count,
    output bar_cfg_pkg::bar_addr_t   addr,
    output logic                     cnt_incr,
    output logic                     cnt_clear,
    output logic                     wr,
    output bar_msg_pkg::bar_entry_t  wr_entry,
    output bar_msg_pkg::bar_unlock_t unlock
);

    import bar_cfg_pkg::*;
    import bar_msg_pkg::*;

    warp_mask_t  wid_bit;
    warp_mask_t  wait_mask;
    logic        at_last;
    bar_unlock_t unlock_n;
    logic        unlock_valid_q;
    warp_mask_t  unlock_mask_q;

    // requests win over markers
    assign addr = req_valid ? req.addr : tx.addr;

    assign wid_bit   = warp_mask_t'(1) << req.wid;
    assign wait_mask = entry.mask | wid_bit;

    // this arrival is the last one the barrier expects
    assign at_last = (count == warp_count_t'(req.size_m1));

    always_comb begin
        cnt_incr  = 1'b0;
        cnt_clear = 1'b0;
        wr        = 1'b0;
        wr_entry  = entry;
        unlock_n  = '0;

        if (req_valid) begin
            wr = 1'b1;
            if (req.is_arrive) begin
                if (!at_last) begin
                    cnt_incr = 1'b1;
                    if (!req.is_async) begin
                        wr_entry.mask = wait_mask;
                    end
                end else if (!entry.tx_pending) begin
                    // barrier opens now
                    cnt_clear            = 1'b1;
                    wr_entry.mask        = '0;
                    wr_entry.arrived_all = 1'b0;
                    wr_entry.phase       = !entry.phase;
                    unlock_n.valid       = 1'b1;
                    unlock_n.mask        = req.is_async ? entry.mask : wait_mask;
                end else begin
                    // full, but held open until the transaction finishes
                    cnt_incr             = 1'b1;
                    wr_entry.arrived_all = 1'b1;
                    if (!req.is_async) begin
                        wr_entry.mask = wait_mask;
                    end
                end
            end else if (req.phase != entry.phase) begin
                // stale wait, barrier already moved on
                unlock_n.valid = 1'b1;
                unlock_n.mask  = wid_bit;
            end else begin
                wr_entry.mask = wait_mask;
            end
        end else if (tx_valid) begin
            wr = 1'b1;
            if (!tx.is_done) begin
                wr_entry.tx_pending = 1'b1;
            end else begin
                wr_entry.tx_pending = 1'b0;
                if (entry.arrived_all) begin
                    // release what was held back
                    cnt_clear            = 1'b1;
                    wr_entry.mask        = '0;
                    wr_entry.arrived_all = 1'b0;
                    wr_entry.phase       = !entry.phase;
                    unlock_n.valid       = 1'b1;
                    unlock_n.mask        = entry.mask;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            unlock_valid_q <= 1'b0;
        end else begin
            unlock_valid_q <= unlock_n.valid;
        end
    end

    // mask is zero whenever no unlock is decided
    always_ff @(posedge clk) begin
        unlock_mask_q <= unlock_n.mask;
    end

    assign unlock = '{valid: unlock_valid_q, mask: unlock_mask_q};

    // a release that includes a stalled warp always names that warp
    a_sync_release_mask: assert property (
        @(posedge clk) disable iff (reset)
        (req_valid && unlock_n.valid && !(req.is_arrive && req.is_async))
            |=> (unlock.valid && (unlock.mask != '0) && unlock.mask[$past(req.wid)])
    ) else $error("unlock pulse misses the releasing warp");

endmodule

// File: rtl/bar_unit.sv
// barrier unit top, ties the sequencer to the arrival counters and the state table
`timescale 1ns/10ps

module bar_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  bar_msg_pkg::bar_req_t    req,
    input  logic                     tx_valid,
    input  bar_msg_pkg::bar_tx_t     tx,
    input  bar_cfg_pkg::bar_addr_t   read_addr,
    output logic                     read_phase,
    output bar_msg_pkg::bar_unlock_t unlock
);

    import bar_cfg_pkg::*;
    import bar_msg_pkg::*;

    // active barrier, shared by counter and table
    bar_addr_t   addr;
    logic        cnt_incr;
    logic        cnt_clear;
    warp_count_t count;
    logic        wr;
    bar_entry_t  wr_entry;
    bar_entry_t  entry;

    bar_sequencer sequencer_i (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .tx_valid  (tx_valid),
        .tx        (tx),
        .entry     (entry),
        .count     (count),
        .addr      (addr),
        .cnt_incr  (cnt_incr),
        .cnt_clear (cnt_clear),
        .wr        (wr),
        .wr_entry  (wr_entry),
        .unlock    (unlock)
    );

    bar_arrival_counter counter_i (
        .clk   (clk),
        .reset (reset),
        .addr  (addr),
        .incr  (cnt_incr),
        .clear (cnt_clear),
        .count (count)
    );

    bar_state_table table_i (
        .clk        (clk),
        .reset      (reset),
        .addr       (addr),
        .wr         (wr),
        .wr_entry   (wr_entry),
        .entry      (entry),
        .read_addr  (read_addr),
        .read_phase (read_phase)
    );

endmodule

// File: tb/bar_unit_checks.svh
// compare tasks for the barrier unit testbench, included inside the testbench module
`ifndef BAR_UNIT_CHECKS_SVH
`define BAR_UNIT_CHECKS_SVH

// unlock pulse, mask only matters when a release is expected
task automatic check_unlock(string name, bar_unlock_t expected, bar_unlock_t actual);
    logic match;
    match = (actual.valid === expected.valid);
    if (expected.valid) begin
        match = match && (actual.mask === expected.mask);
    end
    if (match) begin
        pass_count++;
        $display("passed %s unlock valid=%0b mask=%02h", name, actual.valid, actual.mask);
    end else begin
        fail_count++;
        $display("FAILED %s unlock expected valid=%0b mask=%02h actual valid=%0b mask=%02h",
                 name, expected.valid, expected.mask, actual.valid, actual.mask);
    end
endtask

// phase of the row's barrier on the read port
task automatic check_phase(string name, logic expected, logic actual);
    if (actual === expected) begin
        pass_count++;
        $display("passed %s phase=%0b", name, actual);
    end else begin
        fail_count++;
        $display("FAILED %s phase expected %0b actual %0b", name, expected, actual);
    end
endtask

`endif

// File: tb/bar_unit_tb.sv
// self-checking testbench for the barrier unit, applies a stimulus table one row per cycle
`timescale 1ns/10ps

module bar_unit_tb;

    import bar_cfg_pkg::*;
    import bar_msg_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    localparam bar_unlock_t NO_UNLOCK = '0;

    typedef enum logic [1:0] {
        KIND_IDLE,
        KIND_REQ,
        KIND_TX
    } row_kind_t;

    // one stimulus row, its name is kept in a queue alongside
    typedef struct packed {
        row_kind_t   kind;
        bar_req_t    req;
        bar_tx_t     tx;
        bar_addr_t   bar;
        bar_unlock_t exp_unlock;
        logic        exp_phase;
    } row_t;

    logic        clk;
    logic        reset;
    logic        req_valid;
    bar_req_t    req;
    logic        tx_valid;
    bar_tx_t     tx;
    bar_addr_t   read_addr;
    logic        read_phase;
    bar_unlock_t unlock;

    row_t  rows [$];
    string row_names [$];
    int    pass_count;
    int    fail_count;
    logic  rows_ready;

    `include "bar_unit_checks.svh"

    bar_unit bar_unit_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .tx_valid   (tx_valid),
        .tx         (tx),
        .read_addr  (read_addr),
        .read_phase (read_phase),
        .unlock     (unlock)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic bar_req_t arrive_req(warp_id_t wid, bar_addr_t addr, logic is_async,
                                            warp_id_t size_m1);
        bar_req_t r;
        r = '0;
        r.wid       = wid;
        r.addr      = addr;
        r.is_arrive = 1'b1;
        r.is_async  = is_async;
        r.size_m1   = size_m1;
        return r;
    endfunction

    function automatic bar_req_t wait_req(warp_id_t wid, bar_addr_t addr, logic phase);
        bar_req_t r;
        r = '0;
        r.wid   = wid;
        r.addr  = addr;
        r.phase = phase;
        return r;
    endfunction

    function automatic bar_tx_t tx_marker(bar_addr_t addr, logic is_done);
        bar_tx_t t;
        t.addr    = addr;
        t.is_done = is_done;
        return t;
    endfunction

    function automatic bar_unlock_t unlock_of(warp_mask_t mask);
        bar_unlock_t u;
        u.valid = 1'b1;
        u.mask  = mask;
        return u;
    endfunction

    task automatic add_req(string name, bar_req_t r, bar_unlock_t exp_unlock, logic exp_phase);
        row_t row;
        row = '0;
        row.kind       = KIND_REQ;
        row.req        = r;
        row.bar        = r.addr;
        row.exp_unlock = exp_unlock;
        row.exp_phase  = exp_phase;
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic add_tx(string name, bar_tx_t t, bar_unlock_t exp_unlock, logic exp_phase);
        row_t row;
        row = '0;
        row.kind       = KIND_TX;
        row.tx         = t;
        row.bar        = t.addr;
        row.exp_unlock = exp_unlock;
        row.exp_phase  = exp_phase;
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic add_idle(string name, bar_addr_t bar, logic exp_phase);
        row_t row;
        row = '0;
        row.kind       = KIND_IDLE;
        row.bar        = bar;
        row.exp_unlock = NO_UNLOCK;
        row.exp_phase  = exp_phase;
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic build_table();
        // everything idle at phase 0 out of reset
        add_idle("reset b0 idle", 2'd0, 1'b0);
        add_idle("reset b1 idle", 2'd1, 1'b0);
        add_idle("reset b2 idle", 2'd2, 1'b0);
        add_idle("reset b3 idle", 2'd3, 1'b0);
        // size 3 on barrier 0
        add_req("sync b0 w1 arrive", arrive_req(3'd1, 2'd0, 1'b0, 3'd2), NO_UNLOCK, 1'b0);
        add_req("sync b0 w2 arrive", arrive_req(3'd2, 2'd0, 1'b0, 3'd2), NO_UNLOCK, 1'b0);
        add_req("sync b0 w5 opens", arrive_req(3'd5, 2'd0, 1'b0, 3'd2), unlock_of(8'h26), 1'b1);
        add_idle("sync b0 pulse ends", 2'd0, 1'b1);
        // async arrivals release only the waiter
        add_req("async b1 w0 waits", wait_req(3'd0, 2'd1, 1'b0), NO_UNLOCK, 1'b0);
        add_req("async b1 w3 arrive", arrive_req(3'd3, 2'd1, 1'b1, 3'd1), NO_UNLOCK, 1'b0);
        add_req("async b1 w4 opens", arrive_req(3'd4, 2'd1, 1'b1, 3'd1), unlock_of(8'h01), 1'b1);
        add_req("stale b0 w6 wait", wait_req(3'd6, 2'd0, 1'b0), unlock_of(8'h40), 1'b1);
        add_idle("stale b0 phase holds", 2'd0, 1'b1);
        // pending transaction holds barrier 2 open
        add_tx("tx b2 marker start", tx_marker(2'd2, 1'b0), NO_UNLOCK, 1'b0);
        add_req("tx b2 w0 arrive", arrive_req(3'd0, 2'd2, 1'b0, 3'd1), NO_UNLOCK, 1'b0);
        add_req("tx b2 w7 held", arrive_req(3'd7, 2'd2, 1'b0, 3'd1), NO_UNLOCK, 1'b0);
        add_idle("tx b2 still held", 2'd2, 1'b0);
        add_tx("tx b2 marker done", tx_marker(2'd2, 1'b1), unlock_of(8'h81), 1'b1);
        // barriers 2 and 3 interleaved
        add_req("indep b2 w1 arrive", arrive_req(3'd1, 2'd2, 1'b0, 3'd1), NO_UNLOCK, 1'b1);
        add_req("indep b3 w2 arrive", arrive_req(3'd2, 2'd3, 1'b0, 3'd2), NO_UNLOCK, 1'b0);
        add_req("indep b3 w3 arrive", arrive_req(3'd3, 2'd3, 1'b0, 3'd2), NO_UNLOCK, 1'b0);
        add_req("indep b2 w4 opens", arrive_req(3'd4, 2'd2, 1'b0, 3'd1), unlock_of(8'h12), 1'b0);
        add_idle("indep b3 phase holds", 2'd3, 1'b0);
        add_req("indep b3 w5 opens", arrive_req(3'd5, 2'd3, 1'b0, 3'd2), unlock_of(8'h2c), 1'b1);
        add_idle("indep b2 phase holds", 2'd2, 1'b0);
        add_idle("final b0 phase", 2'd0, 1'b1);
        add_idle("final b1 phase", 2'd1, 1'b1);
    endtask

    task automatic apply_row(row_t row);
        req_valid = (row.kind == KIND_REQ);
        tx_valid  = (row.kind == KIND_TX);
        req       = row.req;
        tx        = row.tx;
        read_addr = row.bar;
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        tx_valid   = 1'b0;
        tx         = '0;
        read_addr  = '0;
        pass_count = 0;
        fail_count = 0;
        rows_ready = 1'b0;
        build_table();
        rows_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        apply_row(rows[0]);

        // results of row i are stable half a cycle after its sampling edge
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            check_unlock(row_names[i], rows[i].exp_unlock, unlock);
            check_phase(row_names[i], rows[i].exp_phase, read_phase);
            if (i + 1 < rows.size()) begin
                apply_row(rows[i + 1]);
            end else begin
                req_valid = 1'b0;
                tx_valid  = 1'b0;
            end
        end

        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog, sized from the table length
    initial begin
        int limit_ns;
        wait (rows_ready === 1'b1);
        limit_ns = (rows.size() + RESET_CYCLES + 20) * CLK_PERIOD;
        #(limit_ns);
        $display("run timed out after %0d ns before all rows were checked", limit_ns);
        $display("Test failed");
        $finish;
    end

endmodule

// File: bar_unit.f
+incdir+tb
rtl/bar_cfg_pkg.sv
rtl/bar_msg_pkg.sv
rtl/bar_arrival_counter.sv
rtl/bar_state_table.sv
rtl/bar_sequencer.sv
rtl/bar_unit.sv
tb/bar_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the barrier unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f bar_unit.f \
    --top-module bar_unit_tb \
    -Mdir obj_dir \
    -o bar_unit_sim

./obj_dir/bar_unit_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation passed"
